// ==== soc_bus_pkg.sv ====
// bus word and strobe types, region codes, bus-error word, irq bits and master indices
`default_nettype none

package soc_bus_pkg;

	// one bus data or address word
	typedef logic [31:0] bus_word_t;

	// byte write strobe, all zero is a read
	typedef logic [3:0] bus_strb_t;

	// region code from the top address nibble
	typedef logic [3:0] region_t;

	localparam region_t REGION_MISC = 4'd2;
	localparam region_t REGION_RAM = 4'd4;

	// returned for any access outside a mapped region
	localparam bus_word_t BUS_ERROR_WORD = 32'hdeadbeef;

	typedef logic [31:0] irq_t;

	// bit 3 flags an access to an unmapped region
	localparam int unsigned IRQ_BUS_ERROR = 3;

	// master indices on the arbiter
	localparam logic MASTER_EXT = 1'b0;
	localparam logic MASTER_DBG = 1'b1;

endpackage

`default_nettype wire

// ==== soc_regs_pkg.sv ====
// misc register index type, register indices and the psram override union
`default_nettype none

package soc_regs_pkg;

	// register index from address bits 5:2
	typedef logic [3:0] misc_idx_t;

	localparam misc_idx_t MISC_REG_LED = 4'd0;
	localparam misc_idx_t MISC_REG_BTN = 4'd1;
	localparam misc_idx_t MISC_REG_SOC_VER = 4'd2;
	localparam misc_idx_t MISC_REG_CPU_NO = 4'd3;
	localparam misc_idx_t MISC_REG_PSRAMOVR_A = 4'd4;
	// index 5 was psram b, no longer mapped
	localparam misc_idx_t MISC_REG_RESETN = 4'd6;

	// pad fields of the override byte, msb first
	typedef struct packed {
		logic override;
		logic oe;
		logic sclk;
		logic nce;
		logic [3:0] sout;
	} psram_ovr_pads_t;

	// written by software as a plain byte, decoded as pad levels
	typedef union packed {
		logic [7:0] raw;
		psram_ovr_pads_t pad;
	} psram_ovr_t;

endpackage

`default_nettype wire

// ==== dbg_loader.sv ====
// debug port loader: fifo of strobed words turned into address loads and word writes
`default_nettype none

module dbg_loader #(
	parameter int FIFO_DEPTH = 16
) (
	input wire logic clk48m,
	input wire logic rst,
	input wire soc_bus_pkg::bus_word_t dbg_in,
	input wire logic dbg_sel,
	input wire logic dbg_strobe,
	output logic m_valid,
	output soc_bus_pkg::bus_word_t m_addr,
	output soc_bus_pkg::bus_word_t m_wdata,
	output soc_bus_pkg::bus_strb_t m_wstrb,
	input wire logic m_ready
);

	localparam int PW = $clog2(FIFO_DEPTH);

	// each entry is {sel, data}
	logic [32:0] fifo_mem [FIFO_DEPTH];
	// one extra pointer bit tells full from empty
	logic [PW:0] wr_ptr;
	logic [PW:0] rd_ptr;
	logic fifo_full;
	logic fifo_empty;
	logic [32:0] head;

	assign fifo_empty = (wr_ptr == rd_ptr);
	assign fifo_full = (wr_ptr[PW] != rd_ptr[PW]) && (wr_ptr[PW-1:0] == rd_ptr[PW-1:0]);
	assign head = fifo_mem[rd_ptr[PW-1:0]];

	// the port only ever writes whole words
	assign m_wstrb = '1;

	// push side, strobes into a full fifo are lost
	always_ff @(posedge clk48m) begin
		if (rst) begin
			wr_ptr <= '0;
		end else if (dbg_strobe && !fifo_full) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk48m) begin
		if (dbg_strobe && !fifo_full) begin
			fifo_mem[wr_ptr[PW-1:0]] <= {dbg_sel, dbg_in};
		end
	end

	// pop side, one entry at a time and never while a write is outstanding
	always_ff @(posedge clk48m) begin
		if (rst) begin
			rd_ptr <= '0;
			m_valid <= 1'b0;
			m_addr <= '0;
		end else if (m_valid) begin
			if (m_ready) begin
				m_valid <= 1'b0;
				m_addr <= m_addr + 32'd4;
			end
		end else if (!fifo_empty) begin
			rd_ptr <= rd_ptr + 1'b1;
			if (head[32]) begin
				m_addr <= head[31:0];
			end else begin
				m_valid <= 1'b1;
			end
		end
	end

	// write data only matters while m_valid is up
	always_ff @(posedge clk48m) begin
		if (!m_valid && !fifo_empty && !head[32]) begin
			m_wdata <= head[31:0];
		end
	end

endmodule

`default_nettype wire

// ==== bus_arbiter.sv ====
// two-master bus arbiter with a registered grant held until the transfer completes
`default_nettype none

module bus_arbiter (
	input wire logic clk48m,
	input wire logic rst,
	input wire logic ext_valid,
	input wire soc_bus_pkg::bus_word_t ext_addr,
	input wire soc_bus_pkg::bus_word_t ext_wdata,
	input wire soc_bus_pkg::bus_strb_t ext_wstrb,
	output soc_bus_pkg::bus_word_t ext_rdata,
	output logic ext_ready,
	input wire logic dbg_valid,
	input wire soc_bus_pkg::bus_word_t dbg_addr,
	input wire soc_bus_pkg::bus_word_t dbg_wdata,
	input wire soc_bus_pkg::bus_strb_t dbg_wstrb,
	output soc_bus_pkg::bus_word_t dbg_rdata,
	output logic dbg_ready,
	output logic s_valid,
	output soc_bus_pkg::bus_word_t s_addr,
	output soc_bus_pkg::bus_word_t s_wdata,
	output soc_bus_pkg::bus_strb_t s_wstrb,
	input wire soc_bus_pkg::bus_word_t s_rdata,
	input wire logic s_ready,
	output logic cur_master
);

	logic granted;
	logic owner;
	logic own_valid;
	logic ext_owns;
	logic dbg_owns;

	assign ext_owns = granted && (owner == soc_bus_pkg::MASTER_EXT);
	assign dbg_owns = granted && (owner == soc_bus_pkg::MASTER_DBG);
	assign own_valid = (owner == soc_bus_pkg::MASTER_DBG) ? dbg_valid : ext_valid;

	// request path follows the owner
	assign s_valid = granted && own_valid;
	assign s_addr = (owner == soc_bus_pkg::MASTER_DBG) ? dbg_addr : ext_addr;
	assign s_wdata = (owner == soc_bus_pkg::MASTER_DBG) ? dbg_wdata : ext_wdata;
	assign s_wstrb = (owner == soc_bus_pkg::MASTER_DBG) ? dbg_wstrb : ext_wstrb;

	// response goes back to the owner only, the other side sees zero
	assign ext_ready = ext_owns && s_ready;
	assign dbg_ready = dbg_owns && s_ready;
	assign ext_rdata = ext_owns ? s_rdata : '0;
	assign dbg_rdata = dbg_owns ? s_rdata : '0;

	assign cur_master = owner;

	always_ff @(posedge clk48m) begin
		if (rst) begin
			granted <= 1'b0;
			owner <= soc_bus_pkg::MASTER_EXT;
		end else if (!granted) begin
			// external port has priority
			if (ext_valid) begin
				granted <= 1'b1;
				owner <= soc_bus_pkg::MASTER_EXT;
			end else if (dbg_valid) begin
				granted <= 1'b1;
				owner <= soc_bus_pkg::MASTER_DBG;
			end
		end else if (s_ready || !own_valid) begin
			granted <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== bus_decoder.sv ====
// region decoder with read mux, ready merge, bus-error detection and irq register
`default_nettype none

module bus_decoder (
	input wire logic clk48m,
	input wire logic rst,
	input wire logic s_valid,
	input wire soc_bus_pkg::bus_word_t s_addr,
	input wire soc_bus_pkg::bus_strb_t s_wstrb,
	output soc_bus_pkg::bus_word_t s_rdata,
	output logic s_ready,
	output logic ram_sel,
	input wire soc_bus_pkg::bus_word_t ram_rdata,
	input wire logic ram_ready,
	output logic misc_sel,
	input wire soc_bus_pkg::bus_word_t misc_rdata,
	output soc_bus_pkg::irq_t irq
);

	soc_bus_pkg::region_t region;
	soc_bus_pkg::bus_word_t read_mux;
	logic bus_error;
	logic is_read;

	assign region = s_addr[31:28];
	assign is_read = (s_wstrb == '0);

	always_comb begin
		ram_sel = 1'b0;
		misc_sel = 1'b0;
		bus_error = 1'b0;
		read_mux = soc_bus_pkg::BUS_ERROR_WORD;
		case (region)
			soc_bus_pkg::REGION_MISC: begin
				misc_sel = s_valid;
				read_mux = misc_rdata;
			end
			soc_bus_pkg::REGION_RAM: begin
				ram_sel = s_valid;
				read_mux = ram_rdata;
			end
			default: begin
				// nothing mapped here, answer at once and flag it
				bus_error = s_valid;
			end
		endcase
	end

	// write cycles return zero read data
	assign s_rdata = is_read ? read_mux : '0;

	// misc and error accesses finish in the select cycle, ram one cycle later
	assign s_ready = ram_ready || misc_sel || bus_error;

	// one-cycle pulse on the bus-error line, the rest stay low
	always_ff @(posedge clk48m) begin
		if (rst) begin
			irq <= '0;
		end else begin
			irq <= '0;
			irq[soc_bus_pkg::IRQ_BUS_ERROR] <= bus_error;
		end
	end

endmodule

`default_nettype wire

// ==== misc_regs.sv ====
// misc register block: led, buttons, version, master number, psram override and cpu resets
`default_nettype none

module misc_regs #(
	parameter soc_bus_pkg::bus_word_t SOC_VERSION = '0
) (
	input wire logic clk48m,
	input wire logic rst,
	input wire logic misc_sel,
	input wire soc_bus_pkg::bus_word_t s_addr,
	input wire soc_bus_pkg::bus_word_t s_wdata,
	input wire soc_bus_pkg::bus_strb_t s_wstrb,
	input wire logic cur_master,
	output soc_bus_pkg::bus_word_t misc_rdata,
	input wire logic [7:0] btn,
	output logic [15:0] led,
	output logic [1:0] cpu_resetn,
	output logic psrama_nce,
	output logic psrama_sclk,
	output logic psrama_oe,
	output logic [3:0] psrama_sout
);

	soc_regs_pkg::misc_idx_t idx;
	soc_regs_pkg::psram_ovr_t psrama_ovr;
	logic wr_en;

	assign idx = s_addr[5:2];
	// only the low strobe bit enables a register write
	assign wr_en = misc_sel && s_wstrb[0];

	always_ff @(posedge clk48m) begin
		if (rst) begin
			led <= '0;
			psrama_ovr.raw <= '0;
			cpu_resetn <= 2'b00;
		end else begin
			// bit 0 is only low in the first cycle out of reset, release both cpus then
			if (!cpu_resetn[0]) begin
				cpu_resetn <= 2'b11;
			end else if (wr_en && idx == soc_regs_pkg::MISC_REG_RESETN) begin
				cpu_resetn[1] <= s_wdata[1];
			end
			if (wr_en && idx == soc_regs_pkg::MISC_REG_LED) begin
				led <= s_wdata[15:0];
			end
			if (wr_en && idx == soc_regs_pkg::MISC_REG_PSRAMOVR_A) begin
				psrama_ovr.raw <= s_wdata[7:0];
			end
		end
	end

	always_comb begin
		case (idx)
			soc_regs_pkg::MISC_REG_LED: misc_rdata = {16'h0, led};
			soc_regs_pkg::MISC_REG_BTN: misc_rdata = {24'h0, ~btn};
			soc_regs_pkg::MISC_REG_SOC_VER: misc_rdata = SOC_VERSION;
			soc_regs_pkg::MISC_REG_CPU_NO: misc_rdata = {31'h0, cur_master};
			soc_regs_pkg::MISC_REG_PSRAMOVR_A: misc_rdata = {24'h0, psrama_ovr.raw};
			default: misc_rdata = '0;
		endcase
	end

	// no qpi controller behind the pads, so idle means deselected
	assign psrama_nce = psrama_ovr.pad.override ? psrama_ovr.pad.nce : 1'b1;
	assign psrama_sclk = psrama_ovr.pad.override ? psrama_ovr.pad.sclk : 1'b0;
	assign psrama_oe = psrama_ovr.pad.override ? psrama_ovr.pad.oe : 1'b0;
	assign psrama_sout = psrama_ovr.pad.override ? psrama_ovr.pad.sout : 4'h0;

endmodule

`default_nettype wire

// ==== scratch_ram.sv ====
// byte-writable on-chip word ram with a registered one-cycle ready
`default_nettype none

module scratch_ram #(
	parameter int RAM_WORDS = 256
) (
	input wire logic clk48m,
	input wire logic rst,
	input wire logic ram_sel,
	input wire soc_bus_pkg::bus_word_t s_addr,
	input wire soc_bus_pkg::bus_word_t s_wdata,
	input wire soc_bus_pkg::bus_strb_t s_wstrb,
	output soc_bus_pkg::bus_word_t ram_rdata,
	output logic ram_ready
);

	localparam int AW = $clog2(RAM_WORDS);

	soc_bus_pkg::bus_word_t mem [RAM_WORDS];
	logic [AW-1:0] word_idx;
	logic ready_q;
	logic first_cycle;

	// word address wraps at the array size
	assign word_idx = AW'(s_addr[31:2] % RAM_WORDS);
	assign first_cycle = ram_sel && !ready_q;

	always_ff @(posedge clk48m) begin
		if (rst) begin
			ready_q <= 1'b0;
		end else begin
			ready_q <= first_cycle;
		end
	end

	// access happens once, in the first select cycle
	always_ff @(posedge clk48m) begin
		if (first_cycle) begin
			for (int b = 0; b < 4; b++) begin
				if (s_wstrb[b]) begin
					mem[word_idx][8*b +: 8] <= s_wdata[8*b +: 8];
				end
			end
			ram_rdata <= mem[word_idx];
		end
	end

	assign ram_ready = ready_q && ram_sel;

endmodule

`default_nettype wire

// ==== soc_fabric.sv ====
// soc bus fabric top: debug loader, arbiter, decoder, misc registers and scratch ram
`default_nettype none

module soc_fabric #(
	parameter int RAM_WORDS = 256,
	parameter int FIFO_DEPTH = 16,
	parameter soc_bus_pkg::bus_word_t SOC_VERSION = '0
) (
	input wire logic clk48m,
	input wire logic rst,
	input wire logic ext_valid,
	input wire soc_bus_pkg::bus_word_t ext_addr,
	input wire soc_bus_pkg::bus_word_t ext_wdata,
	input wire soc_bus_pkg::bus_strb_t ext_wstrb,
	output soc_bus_pkg::bus_word_t ext_rdata,
	output logic ext_ready,
	input wire soc_bus_pkg::bus_word_t dbg_in,
	input wire logic dbg_sel,
	input wire logic dbg_strobe,
	input wire logic [7:0] btn,
	output logic [15:0] led,
	output soc_bus_pkg::irq_t irq,
	output logic [1:0] cpu_resetn,
	output logic psrama_nce,
	output logic psrama_sclk,
	output logic psrama_oe,
	output logic [3:0] psrama_sout
);

	logic dbg_valid;
	soc_bus_pkg::bus_word_t dbg_addr;
	soc_bus_pkg::bus_word_t dbg_wdata;
	soc_bus_pkg::bus_strb_t dbg_wstrb;
	logic dbg_ready;

	logic s_valid;
	soc_bus_pkg::bus_word_t s_addr;
	soc_bus_pkg::bus_word_t s_wdata;
	soc_bus_pkg::bus_strb_t s_wstrb;
	soc_bus_pkg::bus_word_t s_rdata;
	logic s_ready;
	logic cur_master;

	logic ram_sel;
	soc_bus_pkg::bus_word_t ram_rdata;
	logic ram_ready;
	logic misc_sel;
	soc_bus_pkg::bus_word_t misc_rdata;

	dbg_loader #(.FIFO_DEPTH(FIFO_DEPTH)) u_dbg_loader (
		.clk48m(clk48m), .rst(rst),
		.dbg_in(dbg_in), .dbg_sel(dbg_sel), .dbg_strobe(dbg_strobe),
		.m_valid(dbg_valid), .m_addr(dbg_addr), .m_wdata(dbg_wdata),
		.m_wstrb(dbg_wstrb), .m_ready(dbg_ready)
	);

	// the loader only writes, its read data is left open
	bus_arbiter u_bus_arbiter (
		.clk48m(clk48m), .rst(rst),
		.ext_valid(ext_valid), .ext_addr(ext_addr), .ext_wdata(ext_wdata),
		.ext_wstrb(ext_wstrb), .ext_rdata(ext_rdata), .ext_ready(ext_ready),
		.dbg_valid(dbg_valid), .dbg_addr(dbg_addr), .dbg_wdata(dbg_wdata),
		.dbg_wstrb(dbg_wstrb), .dbg_rdata(), .dbg_ready(dbg_ready),
		.s_valid(s_valid), .s_addr(s_addr), .s_wdata(s_wdata), .s_wstrb(s_wstrb),
		.s_rdata(s_rdata), .s_ready(s_ready), .cur_master(cur_master)
	);

	bus_decoder u_bus_decoder (
		.clk48m(clk48m), .rst(rst),
		.s_valid(s_valid), .s_addr(s_addr), .s_wstrb(s_wstrb),
		.s_rdata(s_rdata), .s_ready(s_ready),
		.ram_sel(ram_sel), .ram_rdata(ram_rdata), .ram_ready(ram_ready),
		.misc_sel(misc_sel), .misc_rdata(misc_rdata), .irq(irq)
	);

	misc_regs #(.SOC_VERSION(SOC_VERSION)) u_misc_regs (
		.clk48m(clk48m), .rst(rst),
		.misc_sel(misc_sel), .s_addr(s_addr), .s_wdata(s_wdata), .s_wstrb(s_wstrb),
		.cur_master(cur_master), .misc_rdata(misc_rdata), .btn(btn), .led(led),
		.cpu_resetn(cpu_resetn), .psrama_nce(psrama_nce), .psrama_sclk(psrama_sclk),
		.psrama_oe(psrama_oe), .psrama_sout(psrama_sout)
	);

	scratch_ram #(.RAM_WORDS(RAM_WORDS)) u_scratch_ram (
		.clk48m(clk48m), .rst(rst),
		.ram_sel(ram_sel), .s_addr(s_addr), .s_wdata(s_wdata), .s_wstrb(s_wstrb),
		.ram_rdata(ram_rdata), .ram_ready(ram_ready)
	);

endmodule

`default_nettype wire

// ==== soc_fabric_asserts.sv ====
// bound decoder checks: ready needs valid, irq follows an unmapped access, ram ready needs select
`default_nettype none

module soc_fabric_asserts (
	input wire logic clk48m,
	input wire logic rst,
	input wire logic s_valid,
	input wire soc_bus_pkg::bus_word_t s_addr,
	input wire logic s_ready,
	input wire logic ram_sel,
	input wire logic ram_ready,
	input wire soc_bus_pkg::irq_t irq
);

	int assert_failures = 0;
	logic unmapped;

	assign unmapped = s_valid && (s_addr[31:28] != soc_bus_pkg::REGION_MISC)
		&& (s_addr[31:28] != soc_bus_pkg::REGION_RAM);

	ready_needs_valid: assert property (@(posedge clk48m) disable iff (rst)
		s_ready |-> s_valid)
		else begin
			assert_failures++;
			$error("s_ready high without s_valid");
		end

	// the bus-error bit only follows an unmapped access
	irq_after_error: assert property (@(posedge clk48m) disable iff (rst)
		irq[soc_bus_pkg::IRQ_BUS_ERROR] |-> $past(unmapped))
		else begin
			assert_failures++;
			$error("irq bus-error bit set without an unmapped access");
		end

	ram_ready_needs_sel: assert property (@(posedge clk48m) disable iff (rst)
		ram_ready |-> ram_sel)
		else begin
			assert_failures++;
			$error("ram_ready high without ram_sel");
		end

endmodule

bind bus_decoder soc_fabric_asserts u_bus_asserts (
	.clk48m(clk48m), .rst(rst), .s_valid(s_valid), .s_addr(s_addr), .s_ready(s_ready),
	.ram_sel(ram_sel), .ram_ready(ram_ready), .irq(irq)
);

`default_nettype wire

// ==== tb_soc_fabric.sv ====
// testbench for soc_fabric: clock, reset, lfsr stimulus, reference model, compare tasks, report
`default_nettype none

module tb_soc_fabric;

	localparam int RAM_WORDS = 256;
	localparam int N_RAM = 16;
	localparam int N_DBG = 6;
	localparam int DRAIN_CYCLES = N_DBG * 12;
	// three accesses per ram word, misc traffic, the error read and the debug traffic
	localparam int N_ACCESS = 3 * N_RAM + 14 + 1 + 2 * N_DBG + 1;
	localparam int MAX_CYCLES = N_ACCESS * 40 + DRAIN_CYCLES + 100;

	localparam soc_bus_pkg::bus_word_t MISC_BASE = 32'h2000_0000;
	localparam soc_bus_pkg::bus_word_t RAM_BASE = 32'h4000_0000;
	localparam soc_bus_pkg::bus_word_t HOLE_ADDR = 32'h3000_0010;

	// read word of an unmapped region and the bus-error irq bit 3
	localparam soc_bus_pkg::bus_word_t ERR_WORD = 32'hdead_beef;
	localparam soc_bus_pkg::irq_t ERR_IRQ = 32'h0000_0008;

	logic clk48m;
	logic rst;
	logic ext_valid;
	soc_bus_pkg::bus_word_t ext_addr;
	soc_bus_pkg::bus_word_t ext_wdata;
	soc_bus_pkg::bus_strb_t ext_wstrb;
	soc_bus_pkg::bus_word_t ext_rdata;
	logic ext_ready;
	soc_bus_pkg::bus_word_t dbg_in;
	logic dbg_sel;
	logic dbg_strobe;
	logic [7:0] btn;
	logic [15:0] led;
	soc_bus_pkg::irq_t irq;
	logic [1:0] cpu_resetn;
	logic psrama_nce;
	logic psrama_sclk;
	logic psrama_oe;
	logic [3:0] psrama_sout;

	// reference model state
	soc_bus_pkg::bus_word_t ref_ram [RAM_WORDS];
	logic [15:0] exp_led;
	logic [1:0] exp_resetn;
	logic [7:0] exp_ovr;
	soc_bus_pkg::bus_word_t exp_rd_q [$];
	string name_q [$];

	logic [15:0] lfsr;
	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int err_start = 0;
	int cycle_count = 0;
	int irq_seen = 0;
	string cur_test;

	soc_fabric #(
		.RAM_WORDS(RAM_WORDS),
		.FIFO_DEPTH(16),
		.SOC_VERSION(32'h0)
	) u_soc_fabric (
		.clk48m(clk48m), .rst(rst),
		.ext_valid(ext_valid), .ext_addr(ext_addr), .ext_wdata(ext_wdata),
		.ext_wstrb(ext_wstrb), .ext_rdata(ext_rdata), .ext_ready(ext_ready),
		.dbg_in(dbg_in), .dbg_sel(dbg_sel), .dbg_strobe(dbg_strobe),
		.btn(btn), .led(led), .irq(irq), .cpu_resetn(cpu_resetn),
		.psrama_nce(psrama_nce), .psrama_sclk(psrama_sclk),
		.psrama_oe(psrama_oe), .psrama_sout(psrama_sout)
	);

	initial begin
		clk48m = 1'b0;
	end

	always #20 clk48m = ~clk48m;

	// x^16 + x^14 + x^13 + x^11 + 1, galois form
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic [15:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ 16'hb400;
		end
		return n;
	endfunction

	// one lfsr step per bit taken
	function automatic soc_bus_pkg::bus_word_t rand_bits(input int n);
		soc_bus_pkg::bus_word_t v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// strobed lanes take the new bytes, the others keep the old word
	function automatic soc_bus_pkg::bus_word_t merge_bytes(input soc_bus_pkg::bus_word_t old_word,
			input soc_bus_pkg::bus_word_t wdata, input soc_bus_pkg::bus_strb_t strb);
		soc_bus_pkg::bus_word_t r;
		r = old_word;
		for (int b = 0; b < 4; b++) begin
			if (strb[b]) begin
				r[8*b +: 8] = wdata[8*b +: 8];
			end
		end
		return r;
	endfunction

	function automatic int ram_index(input soc_bus_pkg::bus_word_t addr);
		return int'((addr >> 2) % RAM_WORDS);
	endfunction

	// expected {cpu_resetn, led, nce, sclk, oe, sout}
	function automatic logic [24:0] pins_model(input logic [1:0] resetn, input logic [15:0] led_v,
			input logic [7:0] ovr);
		logic [6:0] pads;
		if (ovr[7]) begin
			pads = {ovr[4], ovr[5], ovr[6], ovr[3:0]};
		end else begin
			pads = {1'b1, 1'b0, 1'b0, 4'h0};
		end
		return {resetn, led_v, pads};
	endfunction

	function automatic logic [24:0] pin_state();
		return {cpu_resetn, led, psrama_nce, psrama_sclk, psrama_oe, psrama_sout};
	endfunction

	task automatic check_word(input string name, input soc_bus_pkg::bus_word_t exp,
			input soc_bus_pkg::bus_word_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_irq(input string name, input soc_bus_pkg::irq_t exp,
			input soc_bus_pkg::irq_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_pins(input string name, input logic [24:0] exp, input logic [24:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED %s expected %h actual %h", name, exp, act);
		end
	endtask

	// request held from a falling edge until ext_ready is seen on a rising edge
	task automatic bus_access(input soc_bus_pkg::bus_word_t addr,
			input soc_bus_pkg::bus_word_t wdata, input soc_bus_pkg::bus_strb_t strb);
		@(negedge clk48m);
		ext_valid = 1'b1;
		ext_addr = addr;
		ext_wdata = wdata;
		ext_wstrb = strb;
		do begin
			@(posedge clk48m);
		end while (!ext_ready);
		@(negedge clk48m);
		ext_valid = 1'b0;
		ext_wstrb = '0;
	endtask

	task automatic bus_write(input soc_bus_pkg::bus_word_t addr,
			input soc_bus_pkg::bus_word_t wdata, input soc_bus_pkg::bus_strb_t strb);
		bus_access(addr, wdata, strb);
	endtask

	task automatic bus_read(input string name, input soc_bus_pkg::bus_word_t addr,
			input soc_bus_pkg::bus_word_t exp);
		exp_rd_q.push_back(exp);
		name_q.push_back(name);
		bus_access(addr, '0, '0);
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		err_start = errors;
		tests_run++;
	endtask

	task automatic finish_test();
		if (errors == err_start) begin
			$display("test %s: ok", cur_test);
		end else begin
			$display("test %s: %0d errors", cur_test, errors - err_start);
		end
	endtask

	// every completed external read is compared with the value queued for it
	always @(posedge clk48m) begin
		if (ext_valid && ext_ready && ext_wstrb == '0) begin
			if (exp_rd_q.size() == 0) begin
				errors++;
				$display("an external read completed with no expected value queued");
			end else begin
				check_word(name_q.pop_front(), exp_rd_q.pop_front(), ext_rdata);
			end
		end
	end

	always @(posedge clk48m) begin
		if (!rst && ((irq & ERR_IRQ) != '0)) begin
			irq_seen++;
		end
	end

	always @(posedge clk48m) begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES) begin
			$display("timeout: the run did not end within %0d cycles", MAX_CYCLES);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	initial begin
		soc_bus_pkg::bus_word_t addr;
		soc_bus_pkg::bus_word_t data;
		soc_bus_pkg::bus_strb_t strb;
		int idx;
		int idx_list [N_RAM];
		logic [7:0] btn_v;
		int base_irq;
		int assert_fails;

		lfsr = 16'd54424;
		rst = 1'b1;
		ext_valid = 1'b0;
		ext_addr = '0;
		ext_wdata = '0;
		ext_wstrb = '0;
		dbg_in = '0;
		dbg_sel = 1'b0;
		dbg_strobe = 1'b0;
		btn = '0;
		repeat (2) @(posedge clk48m);
		@(negedge clk48m);
		rst = 1'b0;

		start_test("reset");
		repeat (2) @(negedge clk48m);
		exp_led = '0;
		exp_resetn = 2'b11;
		exp_ovr = '0;
		check_pins("reset pins", pins_model(exp_resetn, exp_led, exp_ovr), pin_state());
		check_irq("reset irq", '0, irq);
		finish_test();

		start_test("ram");
		for (int i = 0; i < N_RAM; i++) begin
			idx = int'(rand_bits(8)) % RAM_WORDS;
			idx_list[i] = idx;
			addr = RAM_BASE + soc_bus_pkg::bus_word_t'(idx * 4);
			data = rand_bits(32);
			bus_write(addr, data, 4'hf);
			ref_ram[idx] = data;
			data = rand_bits(32);
			strb = soc_bus_pkg::bus_strb_t'(rand_bits(4));
			// an empty strobe would turn the access into a read
			if (strb == '0) begin
				strb = 4'b0001;
			end
			bus_write(addr, data, strb);
			ref_ram[idx] = merge_bytes(ref_ram[idx], data, strb);
		end
		for (int i = 0; i < N_RAM; i++) begin
			addr = RAM_BASE + soc_bus_pkg::bus_word_t'(idx_list[i] * 4);
			bus_read($sformatf("ram word %0d", idx_list[i]), addr, ref_ram[idx_list[i]]);
		end
		finish_test();

		start_test("misc registers");
		data = rand_bits(32);
		bus_write(MISC_BASE, data, 4'hf);
		exp_led = data[15:0];
		bus_read("led readback", MISC_BASE, {16'h0, exp_led});
		check_pins("led pins", pins_model(exp_resetn, exp_led, exp_ovr), pin_state());
		btn_v = 8'(rand_bits(8));
		@(negedge clk48m);
		btn = btn_v;
		bus_read("buttons", MISC_BASE + 32'h4, {24'h0, ~btn_v});
		bus_read("soc version", MISC_BASE + 32'h8, 32'h0);
		bus_read("cpu number", MISC_BASE + 32'hc, 32'h0);
		bus_write(MISC_BASE + 32'h18, 32'h0, 4'hf);
		exp_resetn = 2'b01;
		check_pins("cpu reset held", pins_model(exp_resetn, exp_led, exp_ovr), pin_state());
		bus_write(MISC_BASE + 32'h18, 32'h2, 4'hf);
		exp_resetn = 2'b11;
		check_pins("cpu reset released", pins_model(exp_resetn, exp_led, exp_ovr), pin_state());
		data = rand_bits(32);
		data[7] = 1'b1;
		bus_write(MISC_BASE + 32'h10, data, 4'hf);
		exp_ovr = data[7:0];
		bus_read("override readback", MISC_BASE + 32'h10, {24'h0, exp_ovr});
		check_pins("override pads", pins_model(exp_resetn, exp_led, exp_ovr), pin_state());
		data[7] = 1'b0;
		bus_write(MISC_BASE + 32'h10, data, 4'hf);
		exp_ovr = data[7:0];
		check_pins("idle pads", pins_model(exp_resetn, exp_led, exp_ovr), pin_state());
		finish_test();

		start_test("bus error");
		base_irq = irq_seen;
		bus_read("unmapped read", HOLE_ADDR, ERR_WORD);
		check_irq("irq pulse", ERR_IRQ, irq);
		repeat (4) @(negedge clk48m);
		check_irq("irq clear", '0, irq);
		check_word("irq pulse count", 32'd1, soc_bus_pkg::bus_word_t'(irq_seen - base_irq));
		finish_test();

		start_test("debug loader");
		addr = RAM_BASE + 32'h200;
		@(negedge clk48m);
		dbg_sel = 1'b1;
		dbg_in = addr;
		dbg_strobe = 1'b1;
		for (int k = 0; k < N_DBG; k++) begin
			@(negedge clk48m);
			dbg_sel = 1'b0;
			dbg_in = rand_bits(32);
			ref_ram[ram_index(addr + soc_bus_pkg::bus_word_t'(4 * k))] = dbg_in;
		end
		@(negedge clk48m);
		dbg_strobe = 1'b0;
		repeat (DRAIN_CYCLES) @(negedge clk48m);
		for (int k = 0; k < N_DBG; k++) begin
			data = addr + soc_bus_pkg::bus_word_t'(4 * k);
			bus_read($sformatf("debug word %0d", k), data, ref_ram[ram_index(data)]);
		end
		finish_test();

		assert_fails = u_soc_fabric.u_bus_decoder.u_bus_asserts.assert_failures;
		if (assert_fails != 0) begin
			errors += assert_fails;
			$display("bus assertions failed %0d times", assert_fails);
		end
		if (exp_rd_q.size() != 0) begin
			errors++;
			$display("%0d expected reads were never answered", exp_rd_q.size());
		end
		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
soc_bus_pkg.sv
soc_regs_pkg.sv
dbg_loader.sv
bus_arbiter.sv
bus_decoder.sv
misc_regs.sv
scratch_ram.sv
soc_fabric.sv
soc_fabric_asserts.sv
tb_soc_fabric.sv

// ==== Bender.yml ====
package:
  name: soc_fabric

sources:
  - soc_bus_pkg.sv
  - soc_regs_pkg.sv
  - dbg_loader.sv
  - bus_arbiter.sv
  - bus_decoder.sv
  - misc_regs.sv
  - scratch_ram.sv
  - soc_fabric.sv
  - target: simulation
    files:
      - soc_fabric_asserts.sv
      - tb_soc_fabric.sv
